// ==== design/csr_types_pkg.sv ====
package csr_types_pkg;

  typedef logic [31:0] csr_word_t;
  typedef logic [13:0] csr_addr_t;
  typedef logic [5:0]  ecode_t;
  typedef logic [8:0]  esubcode_t;
  typedef logic [1:0]  plv_t;
  typedef logic [7:0]  hwint_t;
  typedef logic [1:0]  rdcnt_t;
  typedef logic [63:0] counter_t;

  // one flag per exception source
  typedef logic [7:0]  excp_vec_t;

  // positions in excp_vec_t, highest priority first
  localparam int EXCP_INT  = 7;
  localparam int EXCP_ADEF = 6;
  localparam int EXCP_ADEM = 5;
  localparam int EXCP_ALE  = 4;
  localparam int EXCP_SYS  = 3;
  localparam int EXCP_BRK  = 2;
  localparam int EXCP_INE  = 1;
  localparam int EXCP_IPE  = 0;

endpackage

// ==== design/csr_addr_pkg.sv ====
package csr_addr_pkg;

  localparam logic [13:0] CSR_CRMD   = 14'h0;
  localparam logic [13:0] CSR_PRMD   = 14'h1;
  localparam logic [13:0] CSR_ECTL   = 14'h4;
  localparam logic [13:0] CSR_ESTAT  = 14'h5;
  localparam logic [13:0] CSR_ERA    = 14'h6;
  localparam logic [13:0] CSR_BADV   = 14'h7;
  localparam logic [13:0] CSR_EENTRY = 14'hc;
  localparam logic [13:0] CSR_SAVE0  = 14'h30;
  localparam logic [13:0] CSR_SAVE1  = 14'h31;
  localparam logic [13:0] CSR_SAVE2  = 14'h32;
  localparam logic [13:0] CSR_SAVE3  = 14'h33;
  localparam logic [13:0] CSR_TID    = 14'h40;
  localparam logic [13:0] CSR_TCFG   = 14'h41;
  localparam logic [13:0] CSR_TVAL   = 14'h42;
  localparam logic [13:0] CSR_TICLR  = 14'h44;

  // crmd, prmd keeps plv and ie at the same spots
  localparam int CRMD_PLV_LSB  = 0;
  localparam int CRMD_IE       = 2;
  localparam int CRMD_DA       = 3;
  localparam int CRMD_PG       = 4;
  localparam int CRMD_DATF_LSB = 5;
  localparam int CRMD_DATM_LSB = 7;

  localparam int ESTAT_IS_LSB    = 0;
  localparam int ESTAT_TI        = 11;
  localparam int ESTAT_ECODE_LSB = 16;
  localparam int ESTAT_ESUB_LSB  = 22;

  localparam int ECTL_TI   = 11;
  localparam int TICLR_CLR = 0;

  localparam int TCFG_EN          = 0;
  localparam int TCFG_PERIODIC    = 1;
  localparam int TCFG_INITVAL_LSB = 2;

  localparam logic [5:0] ECODE_INT = 6'h0;
  localparam logic [5:0] ECODE_ADE = 6'h8;
  localparam logic [5:0] ECODE_ALE = 6'h9;
  localparam logic [5:0] ECODE_SYS = 6'hb;
  localparam logic [5:0] ECODE_BRK = 6'hc;
  localparam logic [5:0] ECODE_INE = 6'hd;
  localparam logic [5:0] ECODE_IPE = 6'he;
  localparam logic [8:0] ESUB_ADEM = 9'd1;

  localparam logic [1:0] RDCNT_NONE  = 2'd0;
  localparam logic [1:0] RDCNT_ID    = 2'd1;
  localparam logic [1:0] RDCNT_VLOW  = 2'd2;
  localparam logic [1:0] RDCNT_VHIGH = 2'd3;

  // direct address mode out of reset
  localparam logic [31:0] CRMD_RESET = 32'h1 << CRMD_DA;

  localparam logic [31:0] CRMD_WMASK = (32'h3 << CRMD_DATM_LSB) | (32'h3 << CRMD_DATF_LSB) |
    (32'h1 << CRMD_PG) | (32'h1 << CRMD_DA) | (32'h1 << CRMD_IE) | (32'h3 << CRMD_PLV_LSB);
  localparam logic [31:0] PRMD_WMASK   = 32'h0000_0007;
  localparam logic [31:0] ECTL_WMASK   = (32'h3 << ECTL_TI) | 32'h0000_03ff;
  localparam logic [31:0] ESTAT_WMASK  = 32'h0000_0003;
  localparam logic [31:0] EENTRY_WMASK = 32'hffff_ffc0;

endpackage

// ==== design/excp_encoder.sv ====
module excp_encoder (
  input  csr_types_pkg::excp_vec_t excp_i,
  input  csr_types_pkg::csr_word_t pc_i,
  input  csr_types_pkg::csr_word_t vaddr_i,
  output logic                     excp_valid_o,
  output csr_types_pkg::ecode_t    ecode_o,
  output csr_types_pkg::esubcode_t esubcode_o,
  output logic                     badv_we_o,
  output csr_types_pkg::csr_word_t badv_o
);

  logic badv_pc;

  assign excp_valid_o = |excp_i;
  assign badv_o       = badv_pc ? pc_i : vaddr_i;

  // first flag found wins
  always_comb begin
    ecode_o    = csr_addr_pkg::ECODE_INT;
    esubcode_o = '0;
    badv_we_o  = 1'b0;
    badv_pc    = 1'b0;
    if (excp_i[csr_types_pkg::EXCP_INT]) begin
      ecode_o = csr_addr_pkg::ECODE_INT;
    end else if (excp_i[csr_types_pkg::EXCP_ADEF]) begin
      ecode_o   = csr_addr_pkg::ECODE_ADE;
      badv_we_o = 1'b1;
      badv_pc   = 1'b1;
    end else if (excp_i[csr_types_pkg::EXCP_ADEM]) begin
      ecode_o    = csr_addr_pkg::ECODE_ADE;
      esubcode_o = csr_addr_pkg::ESUB_ADEM;
      badv_we_o  = 1'b1;
    end else if (excp_i[csr_types_pkg::EXCP_ALE]) begin
      ecode_o   = csr_addr_pkg::ECODE_ALE;
      badv_we_o = 1'b1;
    end else if (excp_i[csr_types_pkg::EXCP_SYS]) begin
      ecode_o = csr_addr_pkg::ECODE_SYS;
    end else if (excp_i[csr_types_pkg::EXCP_BRK]) begin
      ecode_o = csr_addr_pkg::ECODE_BRK;
    end else if (excp_i[csr_types_pkg::EXCP_INE]) begin
      ecode_o = csr_addr_pkg::ECODE_INE;
    end else if (excp_i[csr_types_pkg::EXCP_IPE]) begin
      ecode_o = csr_addr_pkg::ECODE_IPE;
    end
  end

endmodule

// ==== design/csr_timer.sv ====
module csr_timer (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     commit_i,
  input  logic                     csr_we_i,
  input  csr_types_pkg::csr_addr_t csr_w_addr_i,
  input  csr_types_pkg::csr_word_t csr_w_data_i,
  output csr_types_pkg::csr_word_t tcfg_o,
  output csr_types_pkg::csr_word_t tval_o,
  output logic                     timer_pend_o,
  output logic                     timer_set_o,
  output logic                     timer_clr_o,
  output csr_types_pkg::counter_t  counter_o
);

  logic                     tcfg_we;
  logic                     ticlr_we;
  logic                     en_q;
  logic                     flag_q;
  logic                     pend_q;
  csr_types_pkg::csr_word_t tcfg_q;
  csr_types_pkg::csr_word_t tval_q;
  csr_types_pkg::csr_word_t init_w;
  csr_types_pkg::csr_word_t init_cfg;
  csr_types_pkg::counter_t  cnt_q;

  assign tcfg_we     = csr_we_i && (csr_w_addr_i == csr_addr_pkg::CSR_TCFG);
  assign ticlr_we    = csr_we_i && (csr_w_addr_i == csr_addr_pkg::CSR_TICLR);
  assign timer_clr_o = ticlr_we && csr_w_data_i[csr_addr_pkg::TICLR_CLR];

  // initval in units of four cycles
  assign init_w   = (csr_w_data_i >> csr_addr_pkg::TCFG_INITVAL_LSB) << 2;
  assign init_cfg = (tcfg_q >> csr_addr_pkg::TCFG_INITVAL_LSB) << 2;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      en_q   <= 1'b0;
      flag_q <= 1'b0;
      pend_q <= 1'b0;
      tcfg_q <= '0;
      tval_q <= '0;
      cnt_q  <= '0;
    end else begin
      cnt_q  <= cnt_q + 64'd1;
      flag_q <= en_q && (tval_q == 32'd0 || tval_q == 32'd1);
      if (timer_clr_o) begin
        pend_q <= 1'b0;
      end else if (tcfg_we) begin
        en_q <= csr_w_data_i[csr_addr_pkg::TCFG_EN];
      end else if (flag_q && commit_i) begin
        pend_q <= 1'b1;
        // one-shot stops here
        en_q   <= tcfg_q[csr_addr_pkg::TCFG_PERIODIC];
      end
      if (tcfg_we) begin
        tcfg_q <= csr_w_data_i;
        tval_q <= init_w;
      end else if (en_q) begin
        if (tval_q != 32'd0) begin
          tval_q <= tval_q - 32'd1;
        end else if (commit_i) begin
          tval_q <= tcfg_q[csr_addr_pkg::TCFG_PERIODIC] ? init_cfg : '1;
        end
      end
    end
  end

  assign tcfg_o       = tcfg_q;
  assign tval_o       = tval_q;
  assign timer_pend_o = pend_q;
  assign timer_set_o  = flag_q;
  assign counter_o    = cnt_q;

  a_tval_idle: assert property (@(posedge clk) disable iff (!rst_n)
    !en_q && !tcfg_we |=> tval_q == $past(tval_q))
    else $error("tval moved with timer disabled");

endmodule

// ==== design/csr_regfile.sv ====
module csr_regfile (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     stall_i,
  input  logic                     csr_we_i,
  input  csr_types_pkg::csr_addr_t csr_w_addr_i,
  input  csr_types_pkg::csr_word_t csr_w_mask_i,
  input  csr_types_pkg::csr_word_t csr_w_data_i,
  input  logic                     excp_valid_i,
  input  csr_types_pkg::ecode_t    ecode_i,
  input  csr_types_pkg::esubcode_t esubcode_i,
  input  logic                     badv_we_i,
  input  csr_types_pkg::csr_word_t badv_i,
  input  csr_types_pkg::csr_word_t pc_i,
  input  logic                     ertn_i,
  input  logic                     commit_i,
  input  csr_types_pkg::hwint_t    int_i,
  input  logic                     timer_pend_i,
  input  logic                     timer_set_i,
  input  logic                     timer_clr_i,
  input  csr_types_pkg::csr_word_t tcfg_i,
  input  csr_types_pkg::csr_word_t tval_i,
  output logic                     w_en_o,
  output csr_types_pkg::csr_word_t w_data_o,
  output csr_types_pkg::csr_word_t crmd_o,
  output csr_types_pkg::csr_word_t prmd_o,
  output csr_types_pkg::csr_word_t ectl_o,
  output csr_types_pkg::csr_word_t estat_o,
  output csr_types_pkg::csr_word_t era_o,
  output csr_types_pkg::csr_word_t badv_o,
  output csr_types_pkg::csr_word_t eentry_o,
  output csr_types_pkg::csr_word_t save0_o,
  output csr_types_pkg::csr_word_t save1_o,
  output csr_types_pkg::csr_word_t save2_o,
  output csr_types_pkg::csr_word_t save3_o,
  output csr_types_pkg::csr_word_t tid_o,
  output logic                     m1_int_o
);

  csr_types_pkg::hwint_t    int_q;
  csr_types_pkg::hwint_t    hw_q;
  logic [1:0]               sw_q;
  csr_types_pkg::ecode_t    ecode_q;
  csr_types_pkg::esubcode_t esub_q;
  csr_types_pkg::plv_t      cur_plv;
  csr_types_pkg::csr_word_t cur_w;
  csr_types_pkg::csr_word_t estat_wr;
  csr_types_pkg::csr_word_t irq_w;
  logic                     estat_we;

  assign w_en_o   = csr_we_i && !stall_i;
  assign w_data_o = (cur_w & ~csr_w_mask_i) | (csr_w_data_i & csr_w_mask_i);
  assign estat_we = w_en_o && (csr_w_addr_i == csr_addr_pkg::CSR_ESTAT);
  assign estat_wr = w_data_o & csr_addr_pkg::ESTAT_WMASK;
  assign cur_plv  = crmd_o[csr_addr_pkg::CRMD_PLV_LSB +: 2];

  // old value of the written register, for the mask merge
  always_comb begin
    case (csr_w_addr_i)
      csr_addr_pkg::CSR_CRMD:   cur_w = crmd_o;
      csr_addr_pkg::CSR_PRMD:   cur_w = prmd_o;
      csr_addr_pkg::CSR_ECTL:   cur_w = ectl_o;
      csr_addr_pkg::CSR_ESTAT:  cur_w = estat_o;
      csr_addr_pkg::CSR_ERA:    cur_w = era_o;
      csr_addr_pkg::CSR_BADV:   cur_w = badv_o;
      csr_addr_pkg::CSR_EENTRY: cur_w = eentry_o;
      csr_addr_pkg::CSR_SAVE0:  cur_w = save0_o;
      csr_addr_pkg::CSR_SAVE1:  cur_w = save1_o;
      csr_addr_pkg::CSR_SAVE2:  cur_w = save2_o;
      csr_addr_pkg::CSR_SAVE3:  cur_w = save3_o;
      csr_addr_pkg::CSR_TID:    cur_w = tid_o;
      csr_addr_pkg::CSR_TCFG:   cur_w = tcfg_i;
      csr_addr_pkg::CSR_TVAL:   cur_w = tval_i;
      default:                  cur_w = '0;
    endcase
  end

  always_comb begin
    estat_o = '0;
    estat_o[csr_addr_pkg::ESTAT_IS_LSB +: 2]     = sw_q;
    estat_o[csr_addr_pkg::ESTAT_IS_LSB + 2 +: 8] = hw_q;
    estat_o[csr_addr_pkg::ESTAT_TI]              = timer_pend_i;
    estat_o[csr_addr_pkg::ESTAT_ECODE_LSB +: 6]  = ecode_q;
    estat_o[csr_addr_pkg::ESTAT_ESUB_LSB +: 9]   = esub_q;
  end

  // pending lines with same-cycle sw write and timer set/clear forwarded
  always_comb begin
    irq_w = '0;
    irq_w[csr_addr_pkg::ESTAT_IS_LSB +: 2] =
      estat_we ? estat_wr[csr_addr_pkg::ESTAT_IS_LSB +: 2] : sw_q;
    irq_w[csr_addr_pkg::ESTAT_IS_LSB + 2 +: 8] = int_q;
    irq_w[csr_addr_pkg::ESTAT_TI] = !timer_clr_i && (timer_set_i || timer_pend_i);
  end

  assign m1_int_o = (|(irq_w & ectl_o)) && crmd_o[csr_addr_pkg::CRMD_IE];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      crmd_o   <= csr_addr_pkg::CRMD_RESET;
      prmd_o   <= '0;
      ectl_o   <= '0;
      era_o    <= '0;
      badv_o   <= '0;
      eentry_o <= '0;
      save0_o  <= '0;
      save1_o  <= '0;
      save2_o  <= '0;
      save3_o  <= '0;
      tid_o    <= '0;
      int_q    <= '0;
      hw_q     <= '0;
      sw_q     <= '0;
      ecode_q  <= '0;
      esub_q   <= '0;
    end else begin
      int_q <= int_i;
      if (commit_i) begin
        hw_q <= int_q;
      end
      if (excp_valid_i) begin
        prmd_o[csr_addr_pkg::CRMD_PLV_LSB +: 2] <= cur_plv;
        prmd_o[csr_addr_pkg::CRMD_IE]           <= crmd_o[csr_addr_pkg::CRMD_IE];
        crmd_o[csr_addr_pkg::CRMD_PLV_LSB +: 2] <= '0;
        crmd_o[csr_addr_pkg::CRMD_IE]           <= 1'b0;
        era_o   <= pc_i;
        ecode_q <= ecode_i;
        esub_q  <= esubcode_i;
      end
      if (ertn_i) begin
        crmd_o[csr_addr_pkg::CRMD_PLV_LSB +: 2] <= prmd_o[csr_addr_pkg::CRMD_PLV_LSB +: 2];
        crmd_o[csr_addr_pkg::CRMD_IE]           <= prmd_o[csr_addr_pkg::CRMD_IE];
      end
      if (badv_we_i) begin
        badv_o <= badv_i;
      end
      // csr write last, so it wins over excp and ertn
      if (w_en_o) begin
        case (csr_w_addr_i)
          csr_addr_pkg::CSR_CRMD:   crmd_o   <= w_data_o & csr_addr_pkg::CRMD_WMASK;
          csr_addr_pkg::CSR_PRMD:   prmd_o   <= w_data_o & csr_addr_pkg::PRMD_WMASK;
          csr_addr_pkg::CSR_ECTL:   ectl_o   <= w_data_o & csr_addr_pkg::ECTL_WMASK;
          csr_addr_pkg::CSR_ESTAT:  sw_q     <= estat_wr[csr_addr_pkg::ESTAT_IS_LSB +: 2];
          csr_addr_pkg::CSR_ERA:    era_o    <= w_data_o;
          csr_addr_pkg::CSR_BADV:   badv_o   <= w_data_o;
          csr_addr_pkg::CSR_EENTRY: eentry_o <= w_data_o & csr_addr_pkg::EENTRY_WMASK;
          csr_addr_pkg::CSR_SAVE0:  save0_o  <= w_data_o;
          csr_addr_pkg::CSR_SAVE1:  save1_o  <= w_data_o;
          csr_addr_pkg::CSR_SAVE2:  save2_o  <= w_data_o;
          csr_addr_pkg::CSR_SAVE3:  save3_o  <= w_data_o;
          csr_addr_pkg::CSR_TID:    tid_o    <= w_data_o;
          default: ;
        endcase
      end
    end
  end

  a_excp_ertn: assert property (@(posedge clk) disable iff (!rst_n)
    !(excp_valid_i && ertn_i))
    else $error("exception and ertn in the same cycle");

endmodule

// ==== design/csr_read_port.sv ====
module csr_read_port (
  input  logic                     clk,
  input  logic                     stall_i,
  input  csr_types_pkg::csr_addr_t csr_r_addr_i,
  input  csr_types_pkg::rdcnt_t    rdcnt_i,
  input  csr_types_pkg::csr_word_t crmd_i,
  input  csr_types_pkg::csr_word_t prmd_i,
  input  csr_types_pkg::csr_word_t ectl_i,
  input  csr_types_pkg::csr_word_t estat_i,
  input  csr_types_pkg::csr_word_t era_i,
  input  csr_types_pkg::csr_word_t badv_i,
  input  csr_types_pkg::csr_word_t eentry_i,
  input  csr_types_pkg::csr_word_t save0_i,
  input  csr_types_pkg::csr_word_t save1_i,
  input  csr_types_pkg::csr_word_t save2_i,
  input  csr_types_pkg::csr_word_t save3_i,
  input  csr_types_pkg::csr_word_t tid_i,
  input  csr_types_pkg::csr_word_t tcfg_i,
  input  csr_types_pkg::csr_word_t tval_i,
  input  csr_types_pkg::counter_t  counter_i,
  output csr_types_pkg::csr_word_t csr_r_data_o
);

  csr_types_pkg::csr_word_t rd_w;

  always_comb begin
    case (rdcnt_i)
      csr_addr_pkg::RDCNT_ID:    rd_w = tid_i;
      csr_addr_pkg::RDCNT_VLOW:  rd_w = counter_i[31:0];
      csr_addr_pkg::RDCNT_VHIGH: rd_w = counter_i[63:32];
      csr_addr_pkg::RDCNT_NONE: begin
        case (csr_r_addr_i)
          csr_addr_pkg::CSR_CRMD:   rd_w = crmd_i;
          csr_addr_pkg::CSR_PRMD:   rd_w = prmd_i;
          csr_addr_pkg::CSR_ECTL:   rd_w = ectl_i;
          csr_addr_pkg::CSR_ESTAT:  rd_w = estat_i;
          csr_addr_pkg::CSR_ERA:    rd_w = era_i;
          csr_addr_pkg::CSR_BADV:   rd_w = badv_i;
          csr_addr_pkg::CSR_EENTRY: rd_w = eentry_i;
          csr_addr_pkg::CSR_SAVE0:  rd_w = save0_i;
          csr_addr_pkg::CSR_SAVE1:  rd_w = save1_i;
          csr_addr_pkg::CSR_SAVE2:  rd_w = save2_i;
          csr_addr_pkg::CSR_SAVE3:  rd_w = save3_i;
          csr_addr_pkg::CSR_TID:    rd_w = tid_i;
          csr_addr_pkg::CSR_TCFG:   rd_w = tcfg_i;
          csr_addr_pkg::CSR_TVAL:   rd_w = tval_i;
          // ticlr and holes read zero
          default:                  rd_w = '0;
        endcase
      end
      default: rd_w = '0;
    endcase
  end

  // hold while stalled
  always_ff @(posedge clk) begin
    if (!stall_i) begin
      csr_r_data_o <= rd_w;
    end
  end

endmodule

// ==== design/core_csr.sv ====
module core_csr (
  input  logic                     clk,
  input  logic                     rst_n,
  input  csr_types_pkg::excp_vec_t excp_i,
  input  csr_types_pkg::csr_word_t pc_i,
  input  csr_types_pkg::csr_word_t vaddr_i,
  input  logic                     ertn_i,
  input  csr_types_pkg::hwint_t    int_i,
  input  logic                     commit_i,
  input  logic                     stall_i,
  input  csr_types_pkg::csr_addr_t csr_r_addr_i,
  input  csr_types_pkg::rdcnt_t    rdcnt_i,
  input  logic                     csr_we_i,
  input  csr_types_pkg::csr_addr_t csr_w_addr_i,
  input  csr_types_pkg::csr_word_t csr_w_mask_i,
  input  csr_types_pkg::csr_word_t csr_w_data_i,
  output csr_types_pkg::csr_word_t csr_r_data_o,
  output logic                     m1_int_o
);

  logic                     excp_valid;
  csr_types_pkg::ecode_t    ecode;
  csr_types_pkg::esubcode_t esubcode;
  logic                     badv_we;
  csr_types_pkg::csr_word_t badv_new;
  logic                     w_en;
  csr_types_pkg::csr_word_t w_data;
  csr_types_pkg::csr_word_t tcfg;
  csr_types_pkg::csr_word_t tval;
  logic                     timer_pend;
  logic                     timer_set;
  logic                     timer_clr;
  csr_types_pkg::counter_t  counter;
  csr_types_pkg::csr_word_t crmd;
  csr_types_pkg::csr_word_t prmd;
  csr_types_pkg::csr_word_t ectl;
  csr_types_pkg::csr_word_t estat;
  csr_types_pkg::csr_word_t era;
  csr_types_pkg::csr_word_t badv;
  csr_types_pkg::csr_word_t eentry;
  csr_types_pkg::csr_word_t save0;
  csr_types_pkg::csr_word_t save1;
  csr_types_pkg::csr_word_t save2;
  csr_types_pkg::csr_word_t save3;
  csr_types_pkg::csr_word_t tid;

  excp_encoder u_excp (
    .excp_i, .pc_i, .vaddr_i,
    .excp_valid_o(excp_valid), .ecode_o(ecode), .esubcode_o(esubcode),
    .badv_we_o(badv_we), .badv_o(badv_new)
  );

  csr_timer u_timer (
    .clk, .rst_n, .commit_i,
    .csr_we_i(w_en), .csr_w_addr_i, .csr_w_data_i(w_data),
    .tcfg_o(tcfg), .tval_o(tval), .timer_pend_o(timer_pend),
    .timer_set_o(timer_set), .timer_clr_o(timer_clr), .counter_o(counter)
  );

  csr_regfile u_regfile (
    .clk, .rst_n, .stall_i, .csr_we_i, .csr_w_addr_i, .csr_w_mask_i, .csr_w_data_i,
    .excp_valid_i(excp_valid), .ecode_i(ecode), .esubcode_i(esubcode),
    .badv_we_i(badv_we), .badv_i(badv_new), .pc_i, .ertn_i, .commit_i, .int_i,
    .timer_pend_i(timer_pend), .timer_set_i(timer_set), .timer_clr_i(timer_clr),
    .tcfg_i(tcfg), .tval_i(tval),
    .w_en_o(w_en), .w_data_o(w_data),
    .crmd_o(crmd), .prmd_o(prmd), .ectl_o(ectl), .estat_o(estat), .era_o(era),
    .badv_o(badv), .eentry_o(eentry), .save0_o(save0), .save1_o(save1),
    .save2_o(save2), .save3_o(save3), .tid_o(tid), .m1_int_o
  );

  csr_read_port u_read (
    .clk, .stall_i, .csr_r_addr_i, .rdcnt_i,
    .crmd_i(crmd), .prmd_i(prmd), .ectl_i(ectl), .estat_i(estat), .era_i(era),
    .badv_i(badv), .eentry_i(eentry), .save0_i(save0), .save1_i(save1),
    .save2_i(save2), .save3_i(save3), .tid_i(tid), .tcfg_i(tcfg), .tval_i(tval),
    .counter_i(counter), .csr_r_data_o
  );

endmodule

// ==== tb/tb_core_csr.sv ====
module tb_core_csr;

  localparam int OP_WRITE = 0;
  localparam int OP_READ  = 1;
  localparam int OP_EXCP  = 2;
  localparam int OP_ERTN  = 3;
  localparam int OP_WAIT  = 4;
  localparam int MAX_ENTRIES = 64;

  logic                     clk;
  logic                     rst_n;
  csr_types_pkg::excp_vec_t excp_i;
  csr_types_pkg::csr_word_t pc_i;
  csr_types_pkg::csr_word_t vaddr_i;
  logic                     ertn_i;
  csr_types_pkg::hwint_t    int_i;
  logic                     commit_i;
  logic                     stall_i;
  csr_types_pkg::csr_addr_t csr_r_addr_i;
  csr_types_pkg::rdcnt_t    rdcnt_i;
  logic                     csr_we_i;
  csr_types_pkg::csr_addr_t csr_w_addr_i;
  csr_types_pkg::csr_word_t csr_w_mask_i;
  csr_types_pkg::csr_word_t csr_w_data_i;
  csr_types_pkg::csr_word_t csr_r_data_o;
  logic                     m1_int_o;

  // stimulus table
  int          t_op    [0:MAX_ENTRIES-1];
  logic [13:0] t_addr  [0:MAX_ENTRIES-1];
  logic [31:0] t_mask  [0:MAX_ENTRIES-1];
  logic [31:0] t_data  [0:MAX_ENTRIES-1];
  logic [31:0] t_pc    [0:MAX_ENTRIES-1];
  logic [31:0] t_vaddr [0:MAX_ENTRIES-1];
  logic [7:0]  t_flags [0:MAX_ENTRIES-1];
  logic [31:0] t_exp   [0:MAX_ENTRIES-1];
  int          n_entries;
  logic        table_ready;

  // expected register contents, indexed by csr address
  logic [31:0] model [0:127];
  int          n_checks;
  int          n_errors;

  core_csr dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] writable(input logic [13:0] addr);
    case (addr)
      csr_addr_pkg::CSR_CRMD:   return 32'h0000_01ff;
      csr_addr_pkg::CSR_PRMD:   return 32'h0000_0007;
      csr_addr_pkg::CSR_ECTL:   return 32'h0000_1bff;
      csr_addr_pkg::CSR_EENTRY: return 32'hffff_ffc0;
      default:                  return 32'hffff_ffff;
    endcase
  endfunction

  // {badv from pc, badv written, subcode, code}
  function automatic logic [16:0] excp_info(input logic [7:0] f);
    logic [16:0] r;
    r = '0;
    if (f[csr_types_pkg::EXCP_INT]) r = '0;
    else if (f[csr_types_pkg::EXCP_ADEF]) r = {2'b11, 9'd0, 6'h08};
    else if (f[csr_types_pkg::EXCP_ADEM]) r = {2'b01, 9'd1, 6'h08};
    else if (f[csr_types_pkg::EXCP_ALE]) r = {2'b01, 9'd0, 6'h09};
    else if (f[csr_types_pkg::EXCP_SYS]) r[5:0] = 6'h0b;
    else if (f[csr_types_pkg::EXCP_BRK]) r[5:0] = 6'h0c;
    else if (f[csr_types_pkg::EXCP_INE]) r[5:0] = 6'h0d;
    else if (f[csr_types_pkg::EXCP_IPE]) r[5:0] = 6'h0e;
    return r;
  endfunction

  task automatic push(input int op, input logic [13:0] addr, input logic [31:0] mask,
                      input logic [31:0] data, input logic [31:0] pc,
                      input logic [31:0] vaddr, input logic [7:0] flags);
    logic [31:0] merged;
    logic [16:0] info;
    t_op[n_entries]    = op;
    t_addr[n_entries]  = addr;
    t_mask[n_entries]  = mask;
    t_data[n_entries]  = data;
    t_pc[n_entries]    = pc;
    t_vaddr[n_entries] = vaddr;
    t_flags[n_entries] = flags;
    t_exp[n_entries]   = '0;
    case (op)
      OP_WRITE: begin
        merged = (model[addr] & ~mask) | (data & mask);
        // only the software interrupt bits of estat take a write
        if (addr == csr_addr_pkg::CSR_ESTAT) begin
          model[addr] = (model[addr] & ~32'h3) | (merged & 32'h3);
        end else begin
          model[addr] = merged & writable(addr);
        end
      end
      OP_READ: t_exp[n_entries] = model[addr];
      OP_EXCP: begin
        info = excp_info(flags);
        model[csr_addr_pkg::CSR_PRMD][2:0] = model[csr_addr_pkg::CSR_CRMD][2:0];
        model[csr_addr_pkg::CSR_CRMD][2:0] = 3'b000;
        model[csr_addr_pkg::CSR_ERA] = pc;
        model[csr_addr_pkg::CSR_ESTAT][30:16] = info[14:0];
        if (info[15]) model[csr_addr_pkg::CSR_BADV] = info[16] ? pc : vaddr;
      end
      OP_ERTN: model[csr_addr_pkg::CSR_CRMD][2:0] = model[csr_addr_pkg::CSR_PRMD][2:0];
      default: ;
    endcase
    n_entries++;
  endtask

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string msg);
    n_checks++;
    assert (got === exp)
      else begin
        n_errors++;
        $display("Fail at %0t: %s, got %h expected %h", $time, msg, got, exp);
      end
  endtask

  task automatic check_true(input logic cond, input string msg);
    n_checks++;
    assert (cond === 1'b1)
      else begin
        n_errors++;
        $display("Fail at %0t: %s", $time, msg);
      end
  endtask

  task automatic write_csr(input logic [13:0] addr, input logic [31:0] mask,
                           input logic [31:0] data);
    csr_we_i     = 1'b1;
    csr_w_addr_i = addr;
    csr_w_mask_i = mask;
    csr_w_data_i = data;
    @(negedge clk);
    csr_we_i = 1'b0;
  endtask

  task automatic read_csr(input logic [13:0] addr, output logic [31:0] data);
    csr_r_addr_i = addr;
    rdcnt_i      = csr_addr_pkg::RDCNT_NONE;
    @(negedge clk);
    data = csr_r_data_o;
  endtask

  task automatic read_cnt(input logic [1:0] sel, output logic [31:0] data);
    rdcnt_i = sel;
    @(negedge clk);
    data    = csr_r_data_o;
    rdcnt_i = csr_addr_pkg::RDCNT_NONE;
  endtask

  // m1_int_o settles well before the next rising edge
  task automatic check_irq(input logic exp, input string msg);
    #10;
    check_eq({31'b0, m1_int_o}, {31'b0, exp}, msg);
    @(negedge clk);
  endtask

  task automatic apply_entry(input int i);
    logic [31:0] rd;
    case (t_op[i])
      OP_WRITE: write_csr(t_addr[i], t_mask[i], t_data[i]);
      OP_READ: begin
        read_csr(t_addr[i], rd);
        check_eq(rd, t_exp[i], $sformatf("entry %0d read of %h", i, t_addr[i]));
      end
      OP_EXCP: begin
        excp_i  = t_flags[i];
        pc_i    = t_pc[i];
        vaddr_i = t_vaddr[i];
        @(negedge clk);
        excp_i = '0;
      end
      OP_ERTN: begin
        ertn_i = 1'b1;
        @(negedge clk);
        ertn_i = 1'b0;
      end
      default: @(negedge clk);
    endcase
  endtask

  task automatic build_table();
    for (int a = 0; a < 128; a++) model[a] = '0;
    model[csr_addr_pkg::CSR_CRMD] = 32'h0000_0008;
    for (int k = 0; k < 4; k++) begin
      push(OP_WRITE, csr_addr_pkg::CSR_SAVE0 + k, 32'hffff_ffff, $urandom, 0, 0, 0);
      push(OP_READ, csr_addr_pkg::CSR_SAVE0 + k, 0, 0, 0, 0, 0);
    end
    push(OP_WRITE, csr_addr_pkg::CSR_SAVE1, 32'h0000_ffff, $urandom, 0, 0, 0);
    push(OP_READ, csr_addr_pkg::CSR_SAVE1, 0, 0, 0, 0, 0);
    push(OP_WRITE, csr_addr_pkg::CSR_EENTRY, 32'hffff_ffff, $urandom, 0, 0, 0);
    push(OP_READ, csr_addr_pkg::CSR_EENTRY, 0, 0, 0, 0, 0);
    push(OP_WRITE, csr_addr_pkg::CSR_TID, 32'hffff_ffff, $urandom, 0, 0, 0);
    push(OP_READ, csr_addr_pkg::CSR_TID, 0, 0, 0, 0, 0);
    push(OP_WRITE, csr_addr_pkg::CSR_ECTL, 32'hffff_ffff, $urandom, 0, 0, 0);
    push(OP_READ, csr_addr_pkg::CSR_ECTL, 0, 0, 0, 0, 0);
    push(OP_WRITE, csr_addr_pkg::CSR_ECTL, 32'hffff_ffff, 0, 0, 0, 0);
    push(OP_WRITE, csr_addr_pkg::CSR_PRMD, 32'hffff_ffff, $urandom, 0, 0, 0);
    push(OP_READ, csr_addr_pkg::CSR_PRMD, 0, 0, 0, 0, 0);
    push(OP_WRITE, csr_addr_pkg::CSR_ESTAT, 32'hffff_ffff, 32'hffff_ffff, 0, 0, 0);
    push(OP_READ, csr_addr_pkg::CSR_ESTAT, 0, 0, 0, 0, 0);
    push(OP_WRITE, csr_addr_pkg::CSR_ESTAT, 32'h0000_0003, 0, 0, 0, 0);
    push(OP_READ, 14'h20, 0, 0, 0, 0, 0);
    push(OP_READ, csr_addr_pkg::CSR_TICLR, 0, 0, 0, 0, 0);
    // crmd fields, ending at plv 3 with ie set
    push(OP_WRITE, csr_addr_pkg::CSR_CRMD, 32'hffff_ffff, 32'hffff_ffff, 0, 0, 0);
    push(OP_READ, csr_addr_pkg::CSR_CRMD, 0, 0, 0, 0, 0);
    push(OP_WRITE, csr_addr_pkg::CSR_CRMD, 32'h0000_01f8, 0, 0, 0, 0);
    push(OP_READ, csr_addr_pkg::CSR_CRMD, 0, 0, 0, 0, 0);
    push(OP_EXCP, 0, 0, 0, $urandom, $urandom, 8'h1 << csr_types_pkg::EXCP_ALE);
    push(OP_READ, csr_addr_pkg::CSR_PRMD, 0, 0, 0, 0, 0);
    push(OP_READ, csr_addr_pkg::CSR_CRMD, 0, 0, 0, 0, 0);
    push(OP_READ, csr_addr_pkg::CSR_ERA, 0, 0, 0, 0, 0);
    push(OP_READ, csr_addr_pkg::CSR_ESTAT, 0, 0, 0, 0, 0);
    push(OP_READ, csr_addr_pkg::CSR_BADV, 0, 0, 0, 0, 0);
    push(OP_ERTN, 0, 0, 0, 0, 0, 0);
    push(OP_READ, csr_addr_pkg::CSR_CRMD, 0, 0, 0, 0, 0);
    push(OP_EXCP, 0, 0, 0, $urandom, $urandom, 8'h1 << csr_types_pkg::EXCP_ADEF);
    push(OP_READ, csr_addr_pkg::CSR_BADV, 0, 0, 0, 0, 0);
    push(OP_READ, csr_addr_pkg::CSR_ESTAT, 0, 0, 0, 0, 0);
    push(OP_ERTN, 0, 0, 0, 0, 0, 0);
    push(OP_EXCP, 0, 0, 0, $urandom, $urandom,
         (8'h1 << csr_types_pkg::EXCP_ADEF) | (8'h1 << csr_types_pkg::EXCP_SYS));
    push(OP_READ, csr_addr_pkg::CSR_ESTAT, 0, 0, 0, 0, 0);
    push(OP_READ, csr_addr_pkg::CSR_ERA, 0, 0, 0, 0, 0);
    push(OP_ERTN, 0, 0, 0, 0, 0, 0);
    push(OP_EXCP, 0, 0, 0, $urandom, $urandom, 8'h1 << csr_types_pkg::EXCP_ADEM);
    push(OP_READ, csr_addr_pkg::CSR_ESTAT, 0, 0, 0, 0, 0);
    push(OP_READ, csr_addr_pkg::CSR_BADV, 0, 0, 0, 0, 0);
    push(OP_READ, csr_addr_pkg::CSR_PRMD, 0, 0, 0, 0, 0);
    push(OP_ERTN, 0, 0, 0, 0, 0, 0);
    push(OP_WAIT, 0, 0, 0, 0, 0, 0);
    push(OP_READ, csr_addr_pkg::CSR_CRMD, 0, 0, 0, 0, 0);
  endtask

  initial begin
    int          seed;
    int          k;
    logic [31:0] rd;
    logic [31:0] h1;
    logic [31:0] h2;
    logic [31:0] l1;
    logic [31:0] l2;
    seed         = $urandom(13609);
    rst_n        = 1'b0;
    excp_i       = '0;
    pc_i         = '0;
    vaddr_i      = '0;
    ertn_i       = 1'b0;
    int_i        = '0;
    commit_i     = 1'b1;
    stall_i      = 1'b0;
    csr_r_addr_i = '0;
    rdcnt_i      = csr_addr_pkg::RDCNT_NONE;
    csr_we_i     = 1'b0;
    csr_w_addr_i = '0;
    csr_w_mask_i = '0;
    csr_w_data_i = '0;
    n_checks     = 0;
    n_errors     = 0;
    n_entries    = 0;
    table_ready  = 1'b0;
    build_table();
    table_ready = 1'b1;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    check_irq(1'b0, "m1_int_o after reset");
    for (int i = 0; i < n_entries; i++) apply_entry(i);

    // periodic timer, initval 3 loads tval with 12
    write_csr(csr_addr_pkg::CSR_TCFG, 32'hffff_ffff, (32'd3 << 2) | 32'h3);
    read_csr(csr_addr_pkg::CSR_TVAL, rd);
    check_eq(rd, 32'd12, "tval after tcfg write");
    repeat (4 * 3 + 6) @(negedge clk);
    read_csr(csr_addr_pkg::CSR_ESTAT, rd);
    check_true(rd[11], "estat timer bit after countdown");
    read_csr(csr_addr_pkg::CSR_TVAL, rd);
    check_true(rd < 32'd12, "tval below loaded value");
    write_csr(csr_addr_pkg::CSR_TCFG, 32'hffff_ffff, 0);
    write_csr(csr_addr_pkg::CSR_TICLR, 32'hffff_ffff, 32'h1);
    read_csr(csr_addr_pkg::CSR_ESTAT, rd);
    check_true(rd[11] === 1'b0, "estat timer bit after ticlr");

    // software and hardware interrupt lines
    write_csr(csr_addr_pkg::CSR_CRMD, 32'h0000_0004, 32'h0000_0004);
    write_csr(csr_addr_pkg::CSR_ECTL, 32'hffff_ffff, 32'h0000_0001);
    csr_we_i     = 1'b1;
    csr_w_addr_i = csr_addr_pkg::CSR_ESTAT;
    csr_w_mask_i = 32'h3;
    csr_w_data_i = 32'h1;
    check_irq(1'b1, "m1_int_o in the estat write cycle");
    csr_we_i = 1'b0;
    check_irq(1'b1, "m1_int_o after estat write");
    write_csr(csr_addr_pkg::CSR_ESTAT, 32'h3, 32'h0);
    check_irq(1'b0, "m1_int_o after software bit clear");
    write_csr(csr_addr_pkg::CSR_ECTL, 32'hffff_ffff, 32'h0000_0004);
    int_i = 8'h01;
    k = 0;
    while (!m1_int_o && k < 2) begin
      @(negedge clk);
      k++;
    end
    check_irq(1'b1, "m1_int_o from hardware line 0");
    write_csr(csr_addr_pkg::CSR_CRMD, 32'h0000_0004, 32'h0);
    check_irq(1'b0, "m1_int_o with ie cleared");
    int_i = '0;

    // stall holds the read data and drops the write
    read_csr(csr_addr_pkg::CSR_SAVE0, rd);
    check_eq(rd, model[csr_addr_pkg::CSR_SAVE0], "save0 before stall");
    stall_i      = 1'b1;
    csr_we_i     = 1'b1;
    csr_w_addr_i = csr_addr_pkg::CSR_SAVE0;
    csr_w_mask_i = 32'hffff_ffff;
    csr_w_data_i = ~model[csr_addr_pkg::CSR_SAVE0];
    csr_r_addr_i = csr_addr_pkg::CSR_SAVE1;
    @(negedge clk);
    check_eq(csr_r_data_o, model[csr_addr_pkg::CSR_SAVE0], "read data held in stall");
    csr_we_i = 1'b0;
    stall_i  = 1'b0;
    read_csr(csr_addr_pkg::CSR_SAVE0, rd);
    check_eq(rd, model[csr_addr_pkg::CSR_SAVE0], "save0 after stalled write");

    // counter restarted at reset, so the high half is still zero
    read_cnt(csr_addr_pkg::RDCNT_VHIGH, h1);
    read_cnt(csr_addr_pkg::RDCNT_VLOW, l1);
    read_cnt(csr_addr_pkg::RDCNT_VHIGH, h2);
    read_cnt(csr_addr_pkg::RDCNT_VLOW, l2);
    check_eq(h1, 32'd0, "counter high half on first read");
    check_eq(h2, 32'd0, "counter high half on second read");
    check_true(l2 > l1, "counter low half did not advance");
    read_cnt(csr_addr_pkg::RDCNT_ID, rd);
    check_eq(rd, model[csr_addr_pkg::CSR_TID], "counter id read");

    $display("checks %0d, errors %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // limit scales with the table length
  initial begin
    wait (table_ready);
    repeat (n_entries * 40) @(posedge clk);
    $display("watchdog expired before the tests finished, errors so far %0d", n_errors);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

// ==== list.f ====
design/csr_types_pkg.sv
design/csr_addr_pkg.sv
design/excp_encoder.sv
design/csr_timer.sv
design/csr_regfile.sv
design/csr_read_port.sv
design/core_csr.sv
tb/tb_core_csr.sv
